// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f ntt_share_top.f --top-module ntt_share_tb -Mdir build

run: build
	./build/Vntt_share_tb 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended early"; exit 1)

lint:
	verilator --lint-only --timing -f ntt_share_top.f --top-module ntt_share_tb

clean:
	rm -rf build sim.log

// ==== common/ntt_req_if.sv ====
`timescale 1ns/1ps

interface ntt_req_if
  import ntt_share_pkg::*;
();

  logic          pending;        // Slot holds a job not yet released
  ntt_mode_e     mode;
  ntt_mem_addr_t ntt_base;
  pwo_mem_addr_t pwo_base;
  logic          release_pulse;  // One cycle, from the scheduler

  modport slot (
    output pending, mode, ntt_base, pwo_base,
    input  release_pulse
  );

  modport sched (
    input  pending, mode, ntt_base, pwo_base,
    output release_pulse
  );

endinterface

// ==== common/ntt_share_pkg.sv ====
package ntt_share_pkg;

  localparam int NUM_CLIENTS = 2;
  localparam int NTT_ADDR_W  = 15;
  localparam int PWO_ADDR_W  = 15;

  // Idle cycles between a done and the queued job's start
  localparam int GAP_CYCLES     = 4;
  localparam int RELEASE_CYCLES = 4;  // Settle time before going back to idle

  // Shared counter must reach the longer of the two waits
  localparam int WAIT_CNT_W =
    $clog2((GAP_CYCLES > RELEASE_CYCLES) ? GAP_CYCLES : RELEASE_CYCLES);

  typedef logic [NTT_ADDR_W-1:0] ntt_mem_addr_t;
  typedef logic [PWO_ADDR_W-1:0] pwo_mem_addr_t;
  typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

  typedef enum logic [1:0] {
    NTT_FWD = 2'd0,  // Forward NTT
    NTT_INV = 2'd1,  // Inverse NTT
    PWO_MUL = 2'd2,
    PWO_ACC = 2'd3   // Point-wise multiply and accumulate
  } ntt_mode_e;

  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_RUN,
    SCHED_GAP,
    SCHED_RELEASE
  } sched_state_e;

endpackage

// ==== dv/ntt_share_assert.sv ====
`timescale 1ns/1ps

module ntt_share_assert
  import ntt_share_pkg::*;
(
  input logic                   clk,
  input logic                   reset_n,
  input logic [NUM_CLIENTS-1:0] ntt_enable,
  input logic [NUM_CLIENTS-1:0] busy,
  input logic                   ntt_start,
  input logic                   ntt_done,
  input logic                   rel0,
  input logic                   rel1
);

  logic in_flight;  // Engine holds a started job
  int   fail_count;  // Failed assertions so far

  initial begin
    fail_count = 0;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      in_flight <= 1'b0;
    end else if (ntt_start) begin
      in_flight <= 1'b1;
    end else if (ntt_done) begin
      in_flight <= 1'b0;
    end
  end

  start_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    ntt_start |=> !ntt_start) else begin
    $error("ntt_start longer than one cycle");
    fail_count++;
  end

  no_start_in_flight: assert property (@(posedge clk) disable iff (!reset_n)
    ntt_start |-> !in_flight) else begin
    $error("second start before done");
    fail_count++;
  end

  single_release: assert property (@(posedge clk) disable iff (!reset_n)
    !(rel0 && rel1)) else begin
    $error("release on both slots at once");
    fail_count++;
  end

  no_enable_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
    (ntt_enable & busy) == '0) else begin
    $error("enable while client busy");
    fail_count++;
  end

endmodule

// ==== dv/ntt_share_checker.sv ====
`timescale 1ns/1ps

module ntt_share_checker
  import ntt_share_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [NUM_CLIENTS-1:0] ntt_enable,
  input  ntt_mode_e              mode0,
  input  ntt_mode_e              mode1,
  input  ntt_mem_addr_t          ntt_base0,
  input  ntt_mem_addr_t          ntt_base1,
  input  pwo_mem_addr_t          pwo_base0,
  input  pwo_mem_addr_t          pwo_base1,
  input  logic [NUM_CLIENTS-1:0] busy,
  input  logic                   ntt_start,
  input  ntt_mode_e              ntt_mode,
  input  ntt_mem_addr_t          ntt_mem_base,
  input  pwo_mem_addr_t          pwo_mem_base,
  input  logic                   sampler_valid,
  input  logic                   ntt_done,
  output int                     err_count,
  output int                     start_count
);

  // Own copy of both slots, built from the enables
  logic [NUM_CLIENTS-1:0] pend;
  int   mode_q[NUM_CLIENTS];
  int   nbase_q[NUM_CLIENTS];
  int   pbase_q[NUM_CLIENTS];
  int   clear_at[NUM_CLIENTS];
  int   cyc;
  int   next_start;  // Sample index of the next due start
  int   idle_from;   // First sample where the scheduler is idle again
  int   srv;
  int   nxt;
  logic running;

  initial begin
    err_count   = 0;
    start_count = 0;
  end

  task automatic compare_value(string name, int exp_val, int act_val);
    if (exp_val != act_val) begin
      $display("Error at %0t: %s expected %0h actual %0h", $time, name, exp_val, act_val);
      err_count++;
    end
  endtask

  task automatic report_failure(string what);
    $display("Failure at %0t: %s", $time, what);
    err_count++;
  endtask

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pend       = '0;
      clear_at   = '{-1, -1};
      cyc        = 0;
      next_start = -1;
      idle_from  = 0;
      running    = 1'b0;
      srv        = 0;
      nxt        = 0;
    end else begin
      cyc++;
      for (int i = 0; i < NUM_CLIENTS; i++) begin
        compare_value($sformatf("busy[%0d]", i), pend[i], busy[i]);
      end

      if (ntt_start) begin
        if (next_start != cyc) begin
          report_failure("ntt_start pulsed when no start was due");
        end else begin
          compare_value("ntt_mode", mode_q[nxt], ntt_mode);
          compare_value("ntt_mem_base", nbase_q[nxt], ntt_mem_base);
          compare_value("pwo_mem_base", pbase_q[nxt], pwo_mem_base);
        end
        start_count++;
        running    = 1'b1;
        srv        = nxt;
        next_start = -1;
      end else if (next_start == cyc) begin
        report_failure("an expected ntt_start did not arrive");
        next_start = -1;
      end

      compare_value("sampler_valid", running && srv == 0, sampler_valid);

      // Done in the start cycle does not end the job
      if (running && ntt_done && !ntt_start) begin
        running       = 1'b0;
        clear_at[srv] = cyc + 1;
        if (pend[1 - srv]) begin
          next_start = cyc + GAP_CYCLES + 1;
          nxt        = 1 - srv;
        end else begin
          idle_from = cyc + RELEASE_CYCLES + 1;
        end
      end

      if (!running && next_start < 0 && cyc >= idle_from && pend != '0) begin
        next_start = cyc + 1;
        nxt        = pend[0] ? 0 : 1;  // Client 0 first
      end

      for (int i = 0; i < NUM_CLIENTS; i++) begin
        if (ntt_enable[i]) begin
          if (pend[i]) begin
            report_failure($sformatf("client %0d pulsed enable while busy", i));
          end else begin
            pend[i]    = 1'b1;
            mode_q[i]  = (i == 0) ? mode0 : mode1;
            nbase_q[i] = (i == 0) ? ntt_base0 : ntt_base1;
            pbase_q[i] = (i == 0) ? pwo_base0 : pwo_base1;
          end
        end else if (clear_at[i] == cyc) begin
          pend[i] = 1'b0;
        end
      end
    end
  end

endmodule

// ==== dv/ntt_share_patterns.txt ====
# client mode ntt_base(hex) pwo_base(hex) idle_cycles latency early_done
# early_done 1 adds a done pulse in the start cycle
0 0 0100 4100 2 6 0
1 1 0200 4200 20 5 0
0 2 0300 4300 20 3 0
1 3 0400 4400 0 7 0
0 1 0500 4500 0 4 1
1 0 0600 4600 3 2 0
0 3 7fff 7fff 12 9 0
1 2 1234 5678 1 3 1
0 0 0001 0002 0 1 0
1 1 2aaa 5555 0 6 0
0 2 3c3c 0f0f 15 2 0
1 3 0777 1111 6 4 0

// ==== dv/ntt_share_tb.sv ====
`timescale 1ns/1ps

module ntt_share_tb
  import ntt_share_pkg::*;
();

  logic                   clk;
  logic                   reset_n;
  logic [NUM_CLIENTS-1:0] ntt_enable;
  ntt_mode_e              mode0;
  ntt_mode_e              mode1;
  ntt_mem_addr_t          ntt_base0;
  ntt_mem_addr_t          ntt_base1;
  pwo_mem_addr_t          pwo_base0;
  pwo_mem_addr_t          pwo_base1;
  logic [NUM_CLIENTS-1:0] busy;
  logic                   ntt_start;
  ntt_mode_e              ntt_mode;
  ntt_mem_addr_t          ntt_mem_base;
  pwo_mem_addr_t          pwo_mem_base;
  logic                   sampler_valid;
  logic                   ntt_done;

  // One row per job, filled from the pattern file
  int job_client[$];
  int job_mode[$];
  int job_ntt[$];
  int job_pwo[$];
  int job_idle[$];
  int job_lat[$];
  int job_early[$];

  int lat_by_client[NUM_CLIENTS];  // Latency of each client's current job
  int early_by_client[NUM_CLIENTS];
  int cycle_limit;
  int cycle_cnt;
  int err_count;
  int start_count;

  ntt_share_top ntt_share_top_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .ntt_enable    (ntt_enable),
    .mode0         (mode0),
    .mode1         (mode1),
    .ntt_base0     (ntt_base0),
    .ntt_base1     (ntt_base1),
    .pwo_base0     (pwo_base0),
    .pwo_base1     (pwo_base1),
    .busy          (busy),
    .ntt_start     (ntt_start),
    .ntt_mode      (ntt_mode),
    .ntt_mem_base  (ntt_mem_base),
    .pwo_mem_base  (pwo_mem_base),
    .sampler_valid (sampler_valid),
    .ntt_done      (ntt_done)
  );

  ntt_share_checker checker_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .ntt_enable    (ntt_enable),
    .mode0         (mode0),
    .mode1         (mode1),
    .ntt_base0     (ntt_base0),
    .ntt_base1     (ntt_base1),
    .pwo_base0     (pwo_base0),
    .pwo_base1     (pwo_base1),
    .busy          (busy),
    .ntt_start     (ntt_start),
    .ntt_mode      (ntt_mode),
    .ntt_mem_base  (ntt_mem_base),
    .pwo_mem_base  (pwo_mem_base),
    .sampler_valid (sampler_valid),
    .ntt_done      (ntt_done),
    .err_count     (err_count),
    .start_count   (start_count)
  );

  bind ntt_share_top ntt_share_assert assert_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .ntt_enable (ntt_enable),
    .busy       (busy),
    .ntt_start  (ntt_start),
    .ntt_done   (ntt_done),
    .rel0       (req_if0.release_pulse),
    .rel1       (req_if1.release_pulse)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic read_patterns();
    int    fd;
    int    n;
    int    c, m, nb, pb, idl, lat, early;
    string line;
    fd = $fopen("dv/ntt_share_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != 8'h23) begin  // Skip comment lines
        n = $sscanf(line, "%d %d %h %h %d %d %d", c, m, nb, pb, idl, lat, early);
        if (n == 7) begin
          job_client.push_back(c);
          job_mode.push_back(m);
          job_ntt.push_back(nb);
          job_pwo.push_back(pb);
          job_idle.push_back(idl);
          job_lat.push_back(lat);
          job_early.push_back(early);
        end
      end
    end
    $fclose(fd);
  endtask

  // Engine model answers every start with a done after the job's latency
  initial begin
    int cl;
    ntt_done = 1'b0;
    forever begin
      @(negedge clk);
      if (ntt_start) begin
        cl = sampler_valid ? 0 : 1;
        if (early_by_client[cl] != 0) begin
          ntt_done = 1'b1;  // Lands in the start cycle
        end
        @(negedge clk);
        ntt_done = 1'b0;
        repeat (lat_by_client[cl] - 1) @(negedge clk);
        ntt_done = 1'b1;
        @(negedge clk);
        ntt_done = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles with jobs still outstanding", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int   c;
    int   assert_fails;
    logic joined;
    ntt_enable  = '0;
    mode0       = NTT_FWD;
    mode1       = NTT_FWD;
    ntt_base0   = '0;
    ntt_base1   = '0;
    pwo_base0   = '0;
    pwo_base1   = '0;
    reset_n     = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    lat_by_client   = '{1, 1};
    early_by_client = '{0, 0};
    read_patterns();
    cycle_limit = 20;
    for (int j = 0; j < job_client.size(); j++) begin
      cycle_limit += job_idle[j] + job_lat[j] + GAP_CYCLES + RELEASE_CYCLES + 8;
    end

    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    repeat (3) @(negedge clk);  // Idle window checked right after reset

    for (int j = 0; j < job_client.size(); j++) begin
      c = job_client[j];
      // Idle count 0 on a free client shares the enable cycle of the line before
      joined = (job_idle[j] == 0) && (ntt_enable != '0) && !ntt_enable[c] && !busy[c];
      if (!joined) begin
        if (ntt_enable != '0) begin
          @(negedge clk);
          ntt_enable = '0;
        end
        repeat (job_idle[j]) @(negedge clk);
        while (busy[c]) @(negedge clk);
      end
      lat_by_client[c]   = (job_lat[j] < 1) ? 1 : job_lat[j];
      early_by_client[c] = job_early[j];
      if (c == 0) begin
        mode0     = ntt_mode_e'(job_mode[j]);
        ntt_base0 = ntt_mem_addr_t'(job_ntt[j]);
        pwo_base0 = pwo_mem_addr_t'(job_pwo[j]);
      end else begin
        mode1     = ntt_mode_e'(job_mode[j]);
        ntt_base1 = ntt_mem_addr_t'(job_ntt[j]);
        pwo_base1 = pwo_mem_addr_t'(job_pwo[j]);
      end
      ntt_enable[c] = 1'b1;
    end
    if (ntt_enable != '0) begin
      @(negedge clk);
      ntt_enable = '0;
    end

    while (busy != 0) @(negedge clk);
    repeat (GAP_CYCLES + RELEASE_CYCLES + 4) @(negedge clk);

    assert_fails = ntt_share_top_inst.assert_inst.fail_count;
    if (start_count != job_client.size()) begin
      $display("Only %0d of %0d jobs were started", start_count, job_client.size());
    end
    $display("Checks done with %0d value errors, %0d assertion failures and %0d missing starts",
             err_count, assert_fails, job_client.size() - start_count);
    if (err_count == 0 && assert_fails == 0 && start_count == job_client.size() &&
        job_client.size() > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== ntt_sched/ntt_share_sched.sv ====
`timescale 1ns/1ps

module ntt_share_sched
  import ntt_share_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  ntt_req_if.sched      req0,
  ntt_req_if.sched      req1,
  output logic          ntt_start,
  output ntt_mode_e     ntt_mode,
  output ntt_mem_addr_t ntt_mem_base,
  output pwo_mem_addr_t pwo_mem_base,
  output logic          sampler_valid,
  input  logic          ntt_done
);

  sched_state_e           state;
  logic                   served;     // Client whose job the engine runs
  logic                   queued;     // Client waiting out the guard gap
  wait_cnt_t              wait_cnt;
  logic [NUM_CLIENTS-1:0] release_q;

  logic          pick;
  logic          go;
  logic          done_ok;
  logic          other_pending;
  logic          gap_over;
  logic          release_over;
  ntt_mode_e     pick_mode;
  ntt_mem_addr_t pick_ntt_base;
  pwo_mem_addr_t pick_pwo_base;

  // Done in the start cycle belongs to nothing
  assign done_ok = ntt_done && !ntt_start;

  assign other_pending = served ? req0.pending : req1.pending;

  assign gap_over     = (wait_cnt == wait_cnt_t'(GAP_CYCLES - 1));
  assign release_over = (wait_cnt == wait_cnt_t'(RELEASE_CYCLES - 1));

  // Client 0 wins from idle
  assign pick = (state == SCHED_GAP) ? queued : !req0.pending;

  always_comb begin
    go = 1'b0;
    case (state)
      SCHED_IDLE: go = req0.pending || req1.pending;
      SCHED_GAP:  go = gap_over;
      default:    go = 1'b0;
    endcase
  end

  always_comb begin
    if (pick) begin
      pick_mode     = req1.mode;
      pick_ntt_base = req1.ntt_base;
      pick_pwo_base = req1.pwo_base;
    end else begin
      pick_mode     = req0.mode;
      pick_ntt_base = req0.ntt_base;
      pick_pwo_base = req0.pwo_base;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= SCHED_IDLE;
      served        <= 1'b0;
      queued        <= 1'b0;
      wait_cnt      <= '0;
      ntt_start     <= 1'b0;
      sampler_valid <= 1'b0;
      release_q     <= '0;
    end else begin
      ntt_start <= go;      // Single cycle pulse
      release_q <= '0;

      if (go) begin
        served        <= pick;
        sampler_valid <= !pick;  // Sampler only feeds client 0 jobs
      end

      case (state)
        SCHED_IDLE: begin
          if (go) begin
            state <= SCHED_RUN;
          end
        end

        SCHED_RUN: begin
          if (done_ok) begin
            release_q[served] <= 1'b1;
            sampler_valid     <= 1'b0;
            wait_cnt          <= '0;
            if (other_pending) begin
              queued <= !served;
              state  <= SCHED_GAP;
            end else begin
              state <= SCHED_RELEASE;
            end
          end
        end

        SCHED_GAP: begin
          if (go) begin
            state <= SCHED_RUN;   // Chain straight to the queued client
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end

        SCHED_RELEASE: begin
          if (release_over) begin
            state <= SCHED_IDLE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end

        default: begin
          state <= SCHED_IDLE;
        end
      endcase
    end
  end

  // Engine fields held from one start to the next
  always_ff @(posedge clk) begin
    if (go) begin
      ntt_mode     <= pick_mode;
      ntt_mem_base <= pick_ntt_base;
      pwo_mem_base <= pick_pwo_base;
    end
  end

  assign req0.release_pulse = release_q[0];
  assign req1.release_pulse = release_q[1];

endmodule

// ==== ntt_share_top.f ====
common/ntt_share_pkg.sv
common/ntt_req_if.sv
src/ntt_req_slot.sv
ntt_sched/ntt_share_sched.sv
src/ntt_share_top.sv
dv/ntt_share_checker.sv
dv/ntt_share_assert.sv
dv/ntt_share_tb.sv

// ==== src/ntt_req_slot.sv ====
`timescale 1ns/1ps

module ntt_req_slot
  import ntt_share_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  logic          enable,
  input  ntt_mode_e     mode_in,
  input  ntt_mem_addr_t ntt_base_in,
  input  pwo_mem_addr_t pwo_base_in,
  output logic          busy,
  ntt_req_if.slot       req
);

  logic          pending_q;
  logic          accept;
  ntt_mode_e     mode_q;
  ntt_mem_addr_t ntt_base_q;
  pwo_mem_addr_t pwo_base_q;

  // A job already waiting keeps its fields
  assign accept = enable && !pending_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (req.release_pulse) begin
      pending_q <= 1'b0;  // Job finished in the engine
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mode_q     <= mode_in;
      ntt_base_q <= ntt_base_in;
      pwo_base_q <= pwo_base_in;
    end
  end

  assign req.pending  = pending_q;
  assign req.mode     = mode_q;
  assign req.ntt_base = ntt_base_q;
  assign req.pwo_base = pwo_base_q;

  // Client sees busy for the whole life of its job
  assign busy = pending_q;

endmodule

// ==== src/ntt_share_top.sv ====
`timescale 1ns/1ps

module ntt_share_top
  import ntt_share_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,

  // Client side
  input  logic [NUM_CLIENTS-1:0] ntt_enable,
  input  ntt_mode_e              mode0,
  input  ntt_mode_e              mode1,
  input  ntt_mem_addr_t          ntt_base0,
  input  ntt_mem_addr_t          ntt_base1,
  input  pwo_mem_addr_t          pwo_base0,
  input  pwo_mem_addr_t          pwo_base1,
  output logic [NUM_CLIENTS-1:0] busy,

  // Engine side
  output logic                   ntt_start,
  output ntt_mode_e              ntt_mode,
  output ntt_mem_addr_t          ntt_mem_base,
  output pwo_mem_addr_t          pwo_mem_base,
  output logic                   sampler_valid,
  input  logic                   ntt_done
);

  ntt_req_if req_if0 ();
  ntt_req_if req_if1 ();

  ntt_req_slot slot0_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .enable      (ntt_enable[0]),
    .mode_in     (mode0),
    .ntt_base_in (ntt_base0),
    .pwo_base_in (pwo_base0),
    .busy        (busy[0]),
    .req         (req_if0.slot)
  );

  ntt_req_slot slot1_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .enable      (ntt_enable[1]),
    .mode_in     (mode1),
    .ntt_base_in (ntt_base1),
    .pwo_base_in (pwo_base1),
    .busy        (busy[1]),
    .req         (req_if1.slot)
  );

  // One engine shared by both slots
  ntt_share_sched sched_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .req0          (req_if0.sched),
    .req1          (req_if1.sched),
    .ntt_start     (ntt_start),
    .ntt_mode      (ntt_mode),
    .ntt_mem_base  (ntt_mem_base),
    .pwo_mem_base  (pwo_mem_base),
    .sampler_valid (sampler_valid),
    .ntt_done      (ntt_done)
  );

endmodule
